/* build.f */
src/board_bus_pkg.sv
src/host_cmd_port.sv
src/write_arbiter.sv
src/board_regs.sv
src/hub_regs.sv
src/read_router.sv
src/board_bus_top.sv
tb/tb_board_bus.sv

/* src/board_bus_pkg.sv */
/*
 * Shared types for the board register bus.
 * Address bits 15:12 pick the space and bits 3:0 the quadlet.
 * Only the main and hub spaces are decoded on the board. Every other space is external.
 */
`default_nettype none

package board_bus_pkg;

    typedef logic [15:0] reg_addr_t;    // register address
    typedef logic [31:0] reg_data_t;    // one quadlet

    // address spaces, any value not listed is external
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'd0,
        ADDR_HUB  = 4'd2
    } addr_space_t;

    // ----------------------------------------
    // main space register offsets
    localparam logic [3:0] REG_STATUS  = 4'd0;     // timeout, board id, fw version
    localparam logic [3:0] REG_WDOG    = 4'd1;     // watchdog period in ticks
    localparam logic [3:0] REG_SCRATCH = 4'd2;     // free read/write word

    localparam logic [15:0] FW_VERSION = 16'h0008;

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } cmd_op_t;

    // ----------------------------------------
    // bundles
    typedef struct packed {
        cmd_op_t   op;
        reg_addr_t addr;
        reg_data_t wdata;   // ignored for reads
    } host_cmd_t;

    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        reg_data_t data;
    } bus_wr_t;

    typedef struct packed {
        logic       wen;
        logic [7:0] offset;     // offset inside the main space
        reg_data_t  data;
    } bw_wr_t;

    typedef struct packed {
        reg_data_t data;
        reg_addr_t addr;    // request address this answers
    } rd_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_WAIT,
        READ_WAIT
    } port_state_t;

endpackage

`default_nettype wire

/* src/board_bus_top.sv */
/*
 * Register bus core. Host commands, a block-write source, board and hub registers.
 * The block-write source has priority over host writes on the shared write bus.
 * External reads go out on ext_raddr and must return data in the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module board_bus_top
    import board_bus_pkg::*;
#(
    parameter int unsigned WDOG_TICK_CYCLES = 1000  // clocks per watchdog tick
)
(
    input  wire            sysclk,
    input  wire            rst_n,
    input  wire [3:0]      board_id,        // rotary switch

    // host command and response
    input  wire            cmd_valid,
    output logic           cmd_ready,
    input  wire host_cmd_t cmd,
    output logic           rsp_valid,
    input  wire            rsp_ready,
    output rd_rsp_t        rsp,

    // real-time block write
    input  wire            bw_write_en,
    input  wire bw_wr_t    bw,

    // external read port
    output reg_addr_t      ext_raddr,
    input  wire reg_data_t ext_rdata,

    // watchdog
    input  wire            wdog_clear,
    output logic           wdog_timeout
);

    // ----------------------------------------
    // local wires
    bus_wr_t   host_wr;         // host write request
    logic      host_wr_done;
    bus_wr_t   wr_bus;          // arbitrated write bus
    logic      rd_req;
    reg_addr_t rd_addr;
    logic      rd_room;
    reg_data_t main_rdata;      // board registers
    reg_data_t hub_rdata;       // hub memory

    host_cmd_port i_host_cmd_port (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd          (cmd),
        .host_wr      (host_wr),
        .host_wr_done (host_wr_done),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_room      (rd_room)
    );

    write_arbiter i_write_arbiter (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .bw_write_en  (bw_write_en),
        .bw           (bw),
        .host_wr      (host_wr),
        .host_wr_done (host_wr_done),
        .wr_bus       (wr_bus)
    );

    board_regs #(
        .WDOG_TICK_CYCLES (WDOG_TICK_CYCLES)
    ) i_board_regs (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .board_id     (board_id),
        .wr_bus       (wr_bus),
        .rd_addr      (rd_addr),
        .rd_data      (main_rdata),
        .wdog_clear   (wdog_clear),
        .wdog_timeout (wdog_timeout)
    );

    hub_regs i_hub_regs (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .wr_bus  (wr_bus),
        .rd_addr (rd_addr),
        .rd_data (hub_rdata)
    );

    read_router i_read_router (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_room    (rd_room),
        .main_rdata (main_rdata),
        .hub_rdata  (hub_rdata),
        .ext_raddr  (ext_raddr),
        .ext_rdata  (ext_rdata),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

/* src/board_regs.sv */
/*
 * Board registers: status, watchdog period, scratch.
 * Any main space write or wdog_clear restarts the watchdog.
 * A period of zero disables the timeout. One tick is WDOG_TICK_CYCLES clocks.
 * Read data is combinational. The router decides whether it is used.
 */
`timescale 1ns/1ps
`default_nettype none

module board_regs
    import board_bus_pkg::*;
#(
    parameter int unsigned WDOG_TICK_CYCLES = 1000
)
(
    input  wire          sysclk,
    input  wire          rst_n,
    input  wire [3:0]    board_id,
    input  wire bus_wr_t wr_bus,
    input  wire reg_addr_t rd_addr,
    output reg_data_t    rd_data,
    input  wire          wdog_clear,
    output logic         wdog_timeout
);

    localparam int PRE_W = (WDOG_TICK_CYCLES > 1) ? $clog2(WDOG_TICK_CYCLES) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(WDOG_TICK_CYCLES - 1);

    reg_data_t        scratch;
    logic [15:0]      wdog_period;      // in ticks, 0 = off
    logic [PRE_W-1:0] wdog_pre;         // tick prescaler
    logic [15:0]      wdog_count;       // ticks since last restart
    logic             wdog_tick;
    logic             main_wr;          // any write into the main space
    logic             reg_wr;           // write to one of the board registers
    logic             wdog_restart;
    reg_data_t        status;

    assign main_wr      = wr_bus.wen && (wr_bus.addr[15:12] == ADDR_MAIN);
    assign reg_wr       = main_wr && (wr_bus.addr[7:4] == 4'h0);
    assign wdog_restart = main_wr || wdog_clear;

    // ----------------------------------------
    // writable registers
    always_ff @(posedge sysclk) begin
        if (reg_wr && (wr_bus.addr[3:0] == REG_SCRATCH))
            scratch <= wr_bus.data;
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            wdog_period <= 16'h0000;        // watchdog off after reset
        else if (reg_wr && (wr_bus.addr[3:0] == REG_WDOG))
            wdog_period <= wr_bus.data[15:0];
    end

    // ----------------------------------------
    // watchdog
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            wdog_pre <= '0;
        else if (wdog_restart || wdog_tick)
            wdog_pre <= '0;
        else
            wdog_pre <= wdog_pre + 1'b1;
    end

    assign wdog_tick = (wdog_pre == PRE_LAST);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wdog_count   <= 16'h0000;
            wdog_timeout <= 1'b0;
        end else if (wdog_restart) begin
            wdog_count   <= 16'h0000;
            wdog_timeout <= 1'b0;
        end else if (wdog_period != 16'h0000) begin
            if (wdog_count >= wdog_period)
                wdog_timeout <= 1'b1;       // sticky until restart
            else if (wdog_tick)
                wdog_count <= wdog_count + 1'b1;
        end
    end

    // ----------------------------------------
    // read side
    // bit 31 timeout, 27:24 board id, 15:0 firmware version
    assign status = {wdog_timeout, 3'b000, board_id, 8'h00, FW_VERSION};

    always_comb begin
        case (rd_addr[3:0])
            REG_STATUS:  rd_data = status;
            REG_WDOG:    rd_data = {16'h0000, wdog_period};
            REG_SCRATCH: rd_data = scratch;
            default:     rd_data = '0;      // unused offsets read zero
        endcase
    end

endmodule

`default_nettype wire

/* src/host_cmd_port.sv */
/*
 * Host command port. It holds one command until the command finishes.
 * The host keeps cmd stable while cmd_valid is high.
 * A write waits for host_wr_done and a read waits for rd_room.
 * cmd_ready also rises in the cycle the current command finishes.
 */
`timescale 1ns/1ps
`default_nettype none

module host_cmd_port
    import board_bus_pkg::*;
(
    input  wire            sysclk,
    input  wire            rst_n,
    input  wire            cmd_valid,
    output logic           cmd_ready,
    input  wire host_cmd_t cmd,
    output bus_wr_t        host_wr,
    input  wire            host_wr_done,
    output logic           rd_req,
    output reg_addr_t      rd_addr,
    input  wire            rd_room
);

    port_state_t state;
    port_state_t state_nxt;
    host_cmd_t   cmd_q;         // command being worked on
    logic        cmd_done;      // current command leaves this cycle
    logic        cmd_take;      // handshake on the command port

    // write granted, or read taken by the router
    assign cmd_done  = ((state == WRITE_WAIT) && host_wr_done) ||
                       ((state == READ_WAIT) && rd_room);
    assign cmd_ready = (state == IDLE) || cmd_done;
    assign cmd_take  = cmd_valid && cmd_ready;

    // ----------------------------------------
    // FSM
    always_comb begin
        state_nxt = state;
        if (cmd_take)
            state_nxt = (cmd.op == CMD_WRITE) ? WRITE_WAIT : READ_WAIT;
        else if (cmd_done)
            state_nxt = IDLE;
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge sysclk) begin
        if (cmd_take)
            cmd_q <= cmd;   // latch op, address and data
    end

    // ----------------------------------------
    // requests toward the arbiter and router
    assign host_wr.wen  = (state == WRITE_WAIT);    // held until granted
    assign host_wr.addr = cmd_q.addr;
    assign host_wr.data = cmd_q.wdata;

    assign rd_req  = (state == READ_WAIT);          // held until the router has room
    assign rd_addr = cmd_q.addr;

endmodule

`default_nettype wire

/* src/hub_regs.sv */
/*
 * Hub memory of 16 quadlets, indexed by address bits 3:0.
 * Only hub space writes reach it. Reads are combinational.
 * A quadlet that has not been written since reset reads as zero.
 */
`timescale 1ns/1ps
`default_nettype none

module hub_regs
    import board_bus_pkg::*;
(
    input  wire            sysclk,
    input  wire            rst_n,
    input  wire bus_wr_t   wr_bus,
    input  wire reg_addr_t rd_addr,
    output reg_data_t      rd_data
);

    reg_data_t   hub_mem [16];
    logic [15:0] hub_written;   // one flag per quadlet
    logic        hub_wr;

    assign hub_wr = wr_bus.wen && (wr_bus.addr[15:12] == ADDR_HUB);

    always_ff @(posedge sysclk) begin
        if (hub_wr)
            hub_mem[wr_bus.addr[3:0]] <= wr_bus.data;
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            hub_written <= 16'h0000;
        else if (hub_wr)
            hub_written[wr_bus.addr[3:0]] <= 1'b1;
    end

    // stale contents hidden until first write
    assign rd_data = hub_written[rd_addr[3:0]] ? hub_mem[rd_addr[3:0]] : '0;

endmodule

`default_nettype wire

/* src/read_router.sv */
/*
 * Read router with a single response register.
 * Main space is board data only when address bits 7:4 are zero. Otherwise it is external.
 * ext_rdata must answer ext_raddr within the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module read_router
    import board_bus_pkg::*;
(
    input  wire            sysclk,
    input  wire            rst_n,
    input  wire            rd_req,
    input  wire reg_addr_t rd_addr,
    output logic           rd_room,
    input  wire reg_data_t main_rdata,
    input  wire reg_data_t hub_rdata,
    output reg_addr_t      ext_raddr,
    input  wire reg_data_t ext_rdata,
    output logic           rsp_valid,
    input  wire            rsp_ready,
    output rd_rsp_t        rsp
);

    addr_space_t rd_space;
    logic        main_hit;      // board register read
    reg_data_t   rd_data;       // selected source
    logic        rsp_load;

    assign ext_raddr = rd_addr;                 // external side sees every read
    assign rd_space  = addr_space_t'(rd_addr[15:12]);
    assign main_hit  = (rd_space == ADDR_MAIN) && (rd_addr[7:4] == 4'h0);

    always_comb begin
        if (rd_space == ADDR_HUB)
            rd_data = hub_rdata;
        else if (main_hit)
            rd_data = main_rdata;
        else
            rd_data = ext_rdata;    // other spaces and upper main channels
    end

    // ----------------------------------------
    // response register
    assign rd_room  = !rsp_valid || rsp_ready;  // empty or draining
    assign rsp_load = rd_req && rd_room;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            rsp_valid <= 1'b0;
        else if (rsp_load)
            rsp_valid <= 1'b1;
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    always_ff @(posedge sysclk) begin
        if (rsp_load) begin
            rsp.data <= rd_data;
            rsp.addr <= rd_addr;    // echo request address
        end
    end

endmodule

`default_nettype wire

/* src/write_arbiter.sv */
/*
 * Write bus arbiter. The block-write source always wins.
 * Block-write offsets land in the main space only.
 * The bus is registered, so a granted write shows up one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module write_arbiter
    import board_bus_pkg::*;
(
    input  wire          sysclk,
    input  wire          rst_n,
    input  wire          bw_write_en,
    input  wire bw_wr_t  bw,
    input  wire bus_wr_t host_wr,
    output logic         host_wr_done,
    output bus_wr_t      wr_bus
);

    bus_wr_t   sel;         // write picked this cycle
    logic      wen_q;
    reg_addr_t addr_q;
    reg_data_t data_q;

    always_comb begin
        if (bw_write_en) begin
            sel.wen  = bw.wen;
            sel.addr = {ADDR_MAIN, 4'h0, bw.offset};    // widen offset into main space
            sel.data = bw.data;
        end else begin
            sel = host_wr;
        end
    end

    // host write only counts when it really goes out
    assign host_wr_done = host_wr.wen && !bw_write_en;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            wen_q <= 1'b0;
        else
            wen_q <= sel.wen;   // one clean strobe per selected write
    end

    always_ff @(posedge sysclk) begin
        addr_q <= sel.addr;
        data_q <= sel.data;
    end

    assign wr_bus.wen  = wen_q;
    assign wr_bus.addr = addr_q;
    assign wr_bus.data = data_q;

endmodule

`default_nettype wire

/* tb/tb_board_bus.sv */
/*
 * Directed testbench for the register bus core.
 * The external read port is answered by a model in here: address XOR a fixed pattern.
 * Inputs change on the falling edge. Outputs are sampled 1 ns after it.
 * Hub quadlets that were never written are expected to read zero.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_board_bus
    import board_bus_pkg::*;
();

    localparam int        WDOG_TICK   = 4;
    localparam int        MAX_CYCLES  = 4000;   // all tests need well under 1500 cycles
    localparam reg_data_t EXT_PATTERN = 32'hA5C3_0F96;

    logic        sysclk = 1'b0;
    logic        rst_n;
    logic [3:0]  board_id;
    logic        cmd_valid;
    logic        cmd_ready;
    host_cmd_t   cmd;
    logic        rsp_valid;
    logic        rsp_ready;
    rd_rsp_t     rsp;
    logic        bw_write_en;
    bw_wr_t      bw;
    reg_addr_t   ext_raddr;
    reg_data_t   ext_rdata;
    logic        wdog_clear;
    logic        wdog_timeout;

    int          cycle_count = 0;
    int unsigned seed_val;

    // reference model of what the registers should hold
    reg_data_t   exp_scratch;
    logic [15:0] exp_period = 16'h0000;
    logic        exp_tmo = 1'b0;
    reg_data_t   exp_hub [16];
    reg_addr_t   exp_q [$];                     // reads in flight, oldest first

    board_bus_top #(
        .WDOG_TICK_CYCLES (WDOG_TICK)
    ) i_board_bus_top (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .board_id     (board_id),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd          (cmd),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp          (rsp),
        .bw_write_en  (bw_write_en),
        .bw           (bw),
        .ext_raddr    (ext_raddr),
        .ext_rdata    (ext_rdata),
        .wdog_clear   (wdog_clear),
        .wdog_timeout (wdog_timeout)
    );

    assign ext_rdata = {16'h0000, ext_raddr} ^ EXT_PATTERN;    // daughter board model

    always #4 sysclk = ~sysclk;     // 125 MHz

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("TEST FAILED");
            $fatal(1, "timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    // ----------------------------------------
    // compare tasks
    task automatic report_error(input string msg);
        $display("ERROR @ %0d ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_rdata(input string what, input reg_data_t got, input reg_data_t exp);
        if (got !== exp)
            report_error($sformatf("%s data %h, expected %h", what, got, exp));
    endtask

    task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
            report_error($sformatf("%s address %h, expected %h", what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // ----------------------------------------
    // model and bus helpers
    function automatic reg_data_t exp_read(input reg_addr_t a);
        if (a[15:12] == ADDR_HUB)
            return exp_hub[a[3:0]];
        if ((a[15:12] == ADDR_MAIN) && (a[7:4] == 4'h0)) begin
            case (a[3:0])
                REG_STATUS:  return {exp_tmo, 3'b000, board_id, 8'h00, FW_VERSION};
                REG_WDOG:    return {16'h0000, exp_period};
                REG_SCRATCH: return exp_scratch;
                default:     return '0;
            endcase
        end
        return {16'h0000, a} ^ EXT_PATTERN;    // upper main channels and other spaces
    endfunction

    function automatic reg_addr_t rand_read_addr();
        case ($urandom_range(0, 3))
            0:       return {ADDR_MAIN, 8'h00, 4'($urandom_range(0, 2))};
            1:       return {ADDR_HUB, 8'h00, 4'($urandom_range(0, 15))};
            2:       return {ADDR_MAIN, 4'h0, 4'($urandom_range(1, 15)), 4'($urandom)};
            default: return {4'($urandom_range(3, 15)), 12'($urandom)};
        endcase
    endfunction

    task automatic issue_cmd(input cmd_op_t op, input reg_addr_t addr, input reg_data_t wdata);
        logic taken;
        taken = 1'b0;
        @(negedge sysclk);
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        while (!taken) begin
            #1;
            taken = cmd_ready;      // handshake completes on the coming rising edge
            @(negedge sysclk);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic host_write(input reg_addr_t addr, input reg_data_t data);
        issue_cmd(CMD_WRITE, addr, data);
        if (addr[15:12] == ADDR_HUB)
            exp_hub[addr[3:0]] = data;
        else if ((addr[15:12] == ADDR_MAIN) && (addr[7:4] == 4'h0)) begin
            if (addr[3:0] == REG_SCRATCH)
                exp_scratch = data;
            else if (addr[3:0] == REG_WDOG)
                exp_period = data[15:0];
        end
    endtask

    task automatic take_rsp(output rd_rsp_t r);
        @(negedge sysclk);
        rsp_ready = 1'b1;
        #1;
        while (!rsp_valid) begin
            @(negedge sysclk);
            #1;
        end
        r = rsp;
        @(negedge sysclk);
        rsp_ready = 1'b0;
    endtask

    task automatic read_check(input reg_addr_t addr);
        rd_rsp_t r;
        issue_cmd(CMD_READ, addr, '0);
        take_rsp(r);
        check_addr("read response", r.addr, addr);
        check_rdata("read response", r.data, exp_read(addr));
    endtask

    // ----------------------------------------
    // tests
    task automatic test_status_defaults();
        check_flag("cmd_ready after reset", cmd_ready, 1'b1);
        check_flag("rsp_valid after reset", rsp_valid, 1'b0);
        check_flag("wdog_timeout after reset", wdog_timeout, 1'b0);
        read_check({ADDR_MAIN, 8'h00, REG_STATUS});
        read_check({ADDR_MAIN, 8'h00, REG_WDOG});      // period off after reset
    endtask

    task automatic test_write_readback();
        host_write({ADDR_MAIN, 8'h00, REG_SCRATCH}, $urandom);
        read_check({ADDR_MAIN, 8'h00, REG_SCRATCH});
        repeat (6)
            host_write({ADDR_HUB, 8'h00, 4'($urandom_range(0, 15))}, $urandom);
        for (int i = 0; i < 16; i++)
            read_check({ADDR_HUB, 8'h00, 4'(i)});
        read_check({ADDR_MAIN, 8'h00, 4'h5, 4'h3});     // upper main channel is external
        repeat (3)
            read_check({4'($urandom_range(3, 15)), 12'($urandom)});
    endtask

    task automatic test_bw_priority();
        fork
            begin   // block-write source hammers scratch
                @(negedge sysclk);
                bw_write_en = 1'b1;
                repeat (12) begin
                    bw.wen    = 1'b1;
                    bw.offset = {4'h0, REG_SCRATCH};
                    bw.data   = $urandom;
                    @(negedge sysclk);
                end
                bw_write_en = 1'b0;
                bw.wen      = 1'b0;
            end
            begin   // host writes queue up behind it
                host_write({ADDR_MAIN, 8'h00, REG_SCRATCH}, $urandom);
                host_write({ADDR_HUB, 8'h00, 4'($urandom_range(0, 7))}, $urandom);
                host_write({ADDR_MAIN, 8'h00, REG_SCRATCH}, $urandom);
                host_write({ADDR_HUB, 8'h00, 4'($urandom_range(8, 15))}, $urandom);
            end
        join
        read_check({ADDR_MAIN, 8'h00, REG_SCRATCH});    // last host write wins
        for (int i = 0; i < 16; i++)
            read_check({ADDR_HUB, 8'h00, 4'(i)});

        // a lone block write lands in scratch through the main space
        @(negedge sysclk);
        bw_write_en = 1'b1;
        bw.wen      = 1'b1;
        bw.offset   = {4'h0, REG_SCRATCH};
        bw.data     = $urandom;
        exp_scratch = bw.data;
        @(negedge sysclk);
        bw_write_en = 1'b0;
        bw.wen      = 1'b0;
        read_check({ADDR_MAIN, 8'h00, REG_SCRATCH});
    endtask

    task automatic test_backpressure();
        rd_rsp_t   r;
        reg_addr_t a;
        fork
            repeat (24) begin
                a = rand_read_addr();
                exp_q.push_back(a);
                issue_cmd(CMD_READ, a, '0);
            end
            repeat (24) begin
                repeat ($urandom_range(0, 6)) @(negedge sysclk);   // rsp_ready stays low
                take_rsp(r);
                check_addr("in-order response", r.addr, exp_q[0]);
                check_rdata("in-order response", r.data, exp_read(exp_q[0]));
                void'(exp_q.pop_front());
            end
        join
        @(negedge sysclk);
        rsp_ready = 1'b1;
        repeat (4) @(negedge sysclk);
        check_flag("rsp_valid after last response", rsp_valid, 1'b0);   // nothing duplicated
        rsp_ready = 1'b0;
    endtask

    task automatic test_watchdog();
        host_write({ADDR_MAIN, 8'h00, REG_WDOG}, 32'd3);    // 3 ticks of 4 cycles
        repeat (8) @(negedge sysclk);                       // well before 3 ticks are up
        check_flag("wdog_timeout after period write", wdog_timeout, 1'b0);
        repeat (40) @(negedge sysclk);
        check_flag("wdog_timeout when idle", wdog_timeout, 1'b1);
        exp_tmo = 1'b1;
        read_check({ADDR_MAIN, 8'h00, REG_STATUS});     // bit 31 visible in status
        host_write({ADDR_MAIN, 8'h00, REG_SCRATCH}, $urandom);
        exp_tmo = 1'b0;
        repeat (3) @(negedge sysclk);
        check_flag("wdog_timeout after scratch write", wdog_timeout, 1'b0);
        repeat (40) @(negedge sysclk);
        check_flag("wdog_timeout when idle again", wdog_timeout, 1'b1);
        wdog_clear = 1'b1;
        @(negedge sysclk);
        wdog_clear = 1'b0;
        #1;
        check_flag("wdog_timeout after wdog_clear", wdog_timeout, 1'b0);
        host_write({ADDR_MAIN, 8'h00, REG_WDOG}, 32'd0);    // disabled
        repeat (60) @(negedge sysclk);
        check_flag("wdog_timeout with period 0", wdog_timeout, 1'b0);
        read_check({ADDR_MAIN, 8'h00, REG_STATUS});
    endtask

    // ----------------------------------------
    initial begin
        seed_val    = $urandom(14867);
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rsp_ready   = 1'b0;
        bw_write_en = 1'b0;
        bw          = '0;
        wdog_clear  = 1'b0;
        board_id    = 4'($urandom_range(1, 15));
        for (int i = 0; i < 16; i++)
            exp_hub[i] = '0;
        repeat (16) @(negedge sysclk);
        rst_n = 1'b1;
        @(negedge sysclk);

        test_status_defaults();
        test_write_readback();
        test_bw_priority();
        test_backpressure();
        test_watchdog();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
